// ==== alu_settings.svh ====
/* Widths and opcodes for the sequential ALU
   Counter width must cover DATA_WIDTH-1 iterations */
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// Operand and result width
`define ALU_DATA_WIDTH 16

// Iteration counter, counts W-1 down to 0
`define ALU_CNT_WIDTH ($clog2(`ALU_DATA_WIDTH))

// Opcodes as seen on the command port
`define ALU_OP_ADD 2'd0
`define ALU_OP_SUB 2'd1
`define ALU_OP_MUL 2'd2
`define ALU_OP_DIV 2'd3

`endif

// ==== alu_pkg.sv ====
/* Types shared by the ALU blocks and the testbench
   Widths come from the settings header */
`include "alu_settings.svh"

package alu_pkg;

  typedef logic [`ALU_DATA_WIDTH-1:0]   data_t;  // Operand / result
  typedef logic [2*`ALU_DATA_WIDTH-1:0] wide_t;  // Dividend shift register
  typedef logic [`ALU_CNT_WIDTH-1:0]    cnt_t;   // Iteration counter

  typedef enum logic [1:0] {
    OP_ADD = `ALU_OP_ADD,
    OP_SUB = `ALU_OP_SUB,
    OP_MUL = `ALU_OP_MUL,
    OP_DIV = `ALU_OP_DIV
  } alu_op_e;

  // Sequencer states
  typedef enum logic [3:0] {
    IDLE,
    ADD_RUN,
    SUB_RUN,
    MUL_INIT,
    MUL_RUN,
    NEG_A,
    NEG_B,
    DIV_INIT,
    DIV_RUN,
    DIV_POST,
    DONE
  } alu_state_e;

  // Command on the input port
  typedef struct packed {
    data_t   a;
    data_t   b;
    alu_op_e op;
    logic    is_signed;  // Only affects DIV
  } alu_cmd_t;

  // Decoded command, held for the whole run
  typedef struct packed {
    alu_op_e op;
    logic    div_zero;  // DIV with b == 0
    logic    neg_ops;   // Signed DIV, magnitudes first
    logic    neg_quot;  // Quotient gets negated at the end
  } alu_dec_t;

  // One-hot step strobes
  typedef struct packed {
    logic load;
    logic do_add;
    logic do_sub;
    logic do_neg_a;
    logic do_neg_b;
    logic do_mul;
    logic do_div;
    logic do_post;
  } alu_ctrl_t;

  typedef struct packed {
    data_t data;
    logic  error;
  } alu_res_t;

endpackage

// ==== alu_decode.sv ====
/* Command decode, samples i_cmd only in the load cycle
   Output holds until the next accepted command */
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_decode import alu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  alu_cmd_t i_cmd,
  input  logic     i_load,
  output alu_dec_t o_dec
);

  logic     is_div;
  logic     b_zero;
  logic     sign_diff;
  alu_dec_t dec_d;

  assign is_div    = (i_cmd.op == OP_DIV);
  assign b_zero    = (i_cmd.b == '0);
  // Operand signs differ, quotient ends negative
  assign sign_diff = i_cmd.a[`ALU_DATA_WIDTH-1] ^ i_cmd.b[`ALU_DATA_WIDTH-1];

  // Accept-time classification
  always_comb begin
    dec_d          = '0;
    dec_d.op       = i_cmd.op;
    dec_d.div_zero = is_div && b_zero;      // Error path, no run
    dec_d.neg_ops  = is_div && i_cmd.is_signed;
    dec_d.neg_quot = dec_d.neg_ops && sign_diff;
  end

  // Held from accept to completion
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_dec <= '0;
    end else if (i_load) begin
      o_dec <= dec_d;
    end
  end

endmodule

// ==== alu_control.sv ====
/* Sequencer for the shared-adder ALU, one command in flight
   Dispatch happens the cycle after load, from the registered decode */
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_control import alu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      i_valid,
  input  alu_dec_t  i_dec,
  input  logic      i_taken,
  output logic      o_ready,
  output alu_ctrl_t o_ctrl,
  output logic      o_finish
);

  alu_state_e state_q;
  alu_state_e state_d;
  logic       pend_q;   // Command loaded, waiting for dispatch
  cnt_t       cnt_q;
  logic       cnt_zero;
  logic       running;  // Counter in use

  assign o_ready  = (state_q == IDLE) && !pend_q;
  assign cnt_zero = (cnt_q == '0);
  assign running  = (state_q == MUL_RUN) || (state_q == DIV_RUN);

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (pend_q) begin
          case (i_dec.op)
            OP_ADD: state_d = ADD_RUN;
            OP_SUB: state_d = SUB_RUN;
            OP_MUL: state_d = MUL_INIT;
            default: begin
              if (i_dec.div_zero) state_d = DONE;   // Straight to result
              else if (i_dec.neg_ops) state_d = NEG_A;
              else state_d = DIV_INIT;
            end
          endcase
        end
      end
      ADD_RUN, SUB_RUN: state_d = DONE;
      MUL_INIT: state_d = MUL_RUN;
      MUL_RUN:  if (cnt_zero) state_d = DONE;
      NEG_A:    state_d = NEG_B;
      NEG_B:    state_d = DIV_INIT;
      DIV_INIT: state_d = DIV_RUN;
      DIV_RUN:  if (cnt_zero) state_d = DIV_POST;
      DIV_POST: state_d = DONE;
      DONE:     if (i_taken) state_d = IDLE;    // Back to idle once consumed
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      pend_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      pend_q  <= o_ctrl.load;  // Dispatch always leaves IDLE
    end
  end

  // W-1 preset outside the runs, down count inside
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= cnt_t'(`ALU_DATA_WIDTH - 1);
    end else if (running) begin
      cnt_q <= cnt_q - 1'b1;
    end else begin
      cnt_q <= cnt_t'(`ALU_DATA_WIDTH - 1);
    end
  end

  // Step strobes
  always_comb begin
    o_ctrl          = '0;
    o_ctrl.load     = i_valid && o_ready;
    o_ctrl.do_add   = (state_q == ADD_RUN);
    o_ctrl.do_sub   = (state_q == SUB_RUN);
    o_ctrl.do_neg_a = (state_q == NEG_A);
    o_ctrl.do_neg_b = (state_q == NEG_B);
    o_ctrl.do_mul   = (state_q == MUL_RUN);
    o_ctrl.do_div   = (state_q == DIV_RUN);
    o_ctrl.do_post  = (state_q == DIV_POST);
  end

  // One pulse, on the edge that enters DONE
  assign o_finish = (state_d == DONE) && (state_q != DONE);

endmodule

// ==== alu_execute.sv ====
/* Datapath around one W-bit adder with carry in and out
   MUL keeps the low W product bits and DIV works on magnitudes only */
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_execute import alu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  alu_cmd_t  i_cmd,
  input  alu_ctrl_t i_ctrl,
  input  alu_dec_t  i_dec,
  output data_t     o_data
);

  localparam int W = `ALU_DATA_WIDTH;

  wide_t a_reg;     // Upper half is the partial remainder in DIV
  data_t b_reg;     // Multiplicand / divisor
  data_t acc;       // Sum, product or quotient
  data_t acc_d;     // Value acc takes on the coming edge

  data_t add_a;
  data_t add_b;
  logic  add_cin;
  data_t add_sum;
  logic  add_cout;
  logic  divides;   // Trial subtract did not go negative

  // Adder input select from the one-hot strobes
  always_comb begin
    add_a   = '0;
    add_b   = '0;
    add_cin = 1'b0;
    if (i_ctrl.do_add) begin
      add_a = a_reg[W-1:0];
      add_b = b_reg;
    end else if (i_ctrl.do_sub) begin
      add_a   = a_reg[W-1:0];
      add_b   = ~b_reg;
      add_cin = 1'b1;          // a + ~b + 1
    end else if (i_ctrl.do_neg_a) begin
      add_a   = ~a_reg[W-1:0];
      add_cin = 1'b1;          // Two's complement of a
    end else if (i_ctrl.do_neg_b) begin
      add_a   = ~b_reg;
      add_cin = 1'b1;
    end else if (i_ctrl.do_mul) begin
      add_a = acc;             // Partial product plus shifted b
      add_b = b_reg;
    end else if (i_ctrl.do_div) begin
      // Shifted remainder minus divisor
      add_a   = a_reg[2*W-2:W-1];
      add_b   = ~b_reg;
      add_cin = 1'b1;
    end else if (i_ctrl.do_post) begin
      add_a   = ~acc;          // Negate quotient
      add_cin = 1'b1;
    end
  end

  // The shared adder
  assign {add_cout, add_sum} = {1'b0, add_a} + {1'b0, add_b} + {{W{1'b0}}, add_cin};

  // Bit shifted out of the remainder makes it >= b regardless of the trial
  assign divides = a_reg[2*W-1] | add_cout;

  always_ff @(posedge clk) begin
    if (i_ctrl.load) begin
      a_reg <= {{W{1'b0}}, i_cmd.a};
    end else if (i_ctrl.do_neg_a) begin
      if (a_reg[W-1]) a_reg[W-1:0] <= add_sum;   // Only when negative
    end else if (i_ctrl.do_mul) begin
      a_reg[W-1:0] <= {1'b0, a_reg[W-1:1]};      // Next multiplier bit to LSB
    end else if (i_ctrl.do_div) begin
      if (divides) begin
        a_reg <= {add_sum, a_reg[W-2:0], 1'b0};  // Keep the difference
      end else begin
        a_reg <= {a_reg[2*W-2:0], 1'b0};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_ctrl.load) begin
      b_reg <= i_cmd.b;
    end else if (i_ctrl.do_neg_b) begin
      if (b_reg[W-1]) b_reg <= add_sum;
    end else if (i_ctrl.do_mul) begin
      b_reg <= {b_reg[W-2:0], 1'b0};  // Weight of the next multiplier bit
    end
  end

  // Accumulator cleared at accept so a div-by-zero sees zero
  always_comb begin
    acc_d = acc;
    if (i_ctrl.load) begin
      acc_d = '0;
    end else if (i_ctrl.do_add || i_ctrl.do_sub) begin
      acc_d = add_sum;
    end else if (i_ctrl.do_mul) begin
      if (a_reg[0]) acc_d = add_sum;
    end else if (i_ctrl.do_div) begin
      acc_d = {acc[W-2:0], divides};   // Quotient bits enter MSB first
    end else if (i_ctrl.do_post) begin
      if (i_dec.neg_quot) acc_d = add_sum;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc <= '0;
    end else begin
      acc <= acc_d;
    end
  end

  // Result stage loads on the same edge as the last step
  assign o_data = acc_d;

endmodule

// ==== alu_result.sv ====
/* Result holding stage, stable until the consumer takes it
   Error results always carry zero data */
`timescale 1ns/1ps

module alu_result import alu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     i_finish,
  input  data_t    i_data,
  input  alu_dec_t i_dec,
  input  logic     i_ready,
  output alu_res_t o_res,
  output logic     o_valid,
  output logic     o_taken
);

  // Output handshake completes
  assign o_taken = o_valid && i_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_valid <= 1'b0;
    end else if (i_finish) begin
      o_valid <= 1'b1;
    end else if (o_taken) begin
      o_valid <= 1'b0;
    end
  end

  // Payload captured once per command
  always_ff @(posedge clk) begin
    if (i_finish) begin
      o_res.error <= i_dec.div_zero;
      o_res.data  <= i_dec.div_zero ? '0 : i_data;
    end
  end

endmodule

// ==== alu.sv ====
/* Sequential 16-bit ALU, valid/ready on both sides
   Not pipelined: o_ready only while idle, one command in flight */
`timescale 1ns/1ps

module alu import alu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  alu_cmd_t i_cmd,
  input  logic     i_valid,
  output logic     o_ready,
  output alu_res_t o_res,
  output logic     o_valid,
  input  logic     i_ready
);

  alu_dec_t  dec;
  alu_ctrl_t ctrl;
  data_t     exec_data;
  logic      finish;    // Loads the result stage
  logic      taken;     // Result consumed

  alu_decode u_decode (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_cmd  (i_cmd),
    .i_load (ctrl.load),
    .o_dec  (dec)
  );

  alu_control u_control (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_valid  (i_valid),
    .i_dec    (dec),
    .i_taken  (taken),
    .o_ready  (o_ready),
    .o_ctrl   (ctrl),
    .o_finish (finish)
  );

  alu_execute u_execute (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_cmd  (i_cmd),
    .i_ctrl (ctrl),
    .i_dec  (dec),
    .o_data (exec_data)
  );

  alu_result u_result (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_finish (finish),
    .i_data   (exec_data),
    .i_dec    (dec),
    .i_ready  (i_ready),
    .o_res    (o_res),
    .o_valid  (o_valid),
    .o_taken  (taken)
  );

endmodule

// ==== alu_props.sv ====
/* Handshake properties on the ALU ports, bound into alu
   Sees only the top-level ports, not the sequencer */
`timescale 1ns/1ps

module alu_props import alu_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input logic     i_valid,
  input logic     o_ready,
  input alu_res_t o_res,
  input logic     o_valid,
  input logic     i_ready
);

  // Idle and empty while held in reset
  a_in_reset: assert property (@(posedge clk) !rst_n |-> (o_ready && !o_valid))
    else $error("o_ready low or o_valid high during reset");

  // First edge out of reset
  a_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> (o_ready && !o_valid))
    else $error("ALU not idle right after reset");

  // One command in flight, so never both
  a_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(o_ready && o_valid))
    else $error("o_ready and o_valid high together");

  // Result held under back-pressure
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_res)))
    else $error("Result changed or dropped before it was taken");

  // Idle again the cycle after the take
  a_ready_back: assert property (@(posedge clk) disable iff (!rst_n)
    (o_valid && i_ready) |=> (o_ready && !o_valid))
    else $error("o_ready not back one cycle after the result was taken");

  // And not any earlier
  a_ready_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(o_ready) |-> $past(o_valid && i_ready))
    else $error("o_ready rose without a result being taken");

  // Accepted command always leaves the idle state
  a_accept: assert property (@(posedge clk) disable iff (!rst_n)
    (i_valid && o_ready) |=> !o_ready)
    else $error("o_ready still high after a command was accepted");

endmodule

bind alu alu_props u_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .i_valid (i_valid),
  .o_ready (o_ready),
  .o_res   (o_res),
  .o_valid (o_valid),
  .i_ready (i_ready)
);

// ==== alu_tb.sv ====
/* Testbench for the sequential ALU with directed corner cases, then seeded random traffic
   Result and latency are checked at the output side against a reference model */
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_tb import alu_pkg::*; ();

  localparam int W        = `ALU_DATA_WIDTH;
  localparam int PERIOD   = 4;
  localparam int NUM_CMDS = 400;
  localparam int NUM_DIR  = 16;   // Directed commands come first
  localparam int MAX_LAT  = 30;   // Cycle budget per command with back-pressure

  logic     clk = 1'b0;
  logic     rst_n;
  alu_cmd_t i_cmd;
  logic     i_valid;
  logic     o_ready;
  alu_res_t o_res;
  logic     o_valid;
  logic     i_ready;

  integer   seed = 32'h7bb396fa;
  int       cyc = 0;              // Rising edges so far
  int       accept_edge;          // Edge that took the command in flight
  alu_cmd_t cmd_q[$];             // Accepted and not yet taken
  bit       valid_seen = 1'b0;
  int       n_checked = 0;
  int       value_errs = 0;
  int       lat_errs = 0;
  int       other_errs = 0;
  alu_res_t exp_res;
  int       exp_lat;

  alu uut (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_cmd   (i_cmd),
    .i_valid (i_valid),
    .o_ready (o_ready),
    .o_res   (o_res),
    .o_valid (o_valid),
    .i_ready (i_ready)
  );

  always #(PERIOD/2) clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  function automatic alu_cmd_t make_cmd(alu_op_e op, data_t a, data_t b, logic s);
    alu_cmd_t c;
    c.a         = a;
    c.b         = b;
    c.op        = op;
    c.is_signed = s;
    return c;
  endfunction

  // Overflow, most-negative dividend, mixed signs, divide by zero
  function automatic alu_cmd_t directed_cmd(int idx);
    case (idx)
      0:       return make_cmd(OP_ADD, 16'hFFFF, 16'h0001, 1'b0);
      1:       return make_cmd(OP_SUB, 16'h0000, 16'h0001, 1'b1);
      2:       return make_cmd(OP_MUL, 16'hFFFF, 16'hFFFF, 1'b0);
      3:       return make_cmd(OP_MUL, 16'hFFFF, 16'hFFFF, 1'b1);
      4:       return make_cmd(OP_MUL, 16'h1234, 16'h5678, 1'b1);
      5:       return make_cmd(OP_DIV, 16'hFFFF, 16'h0003, 1'b0);
      6:       return make_cmd(OP_DIV, 16'h0005, 16'h0007, 1'b0);
      7:       return make_cmd(OP_DIV, 16'hFFF9, 16'h0002, 1'b1);  // -7 / 2
      8:       return make_cmd(OP_DIV, 16'h0007, 16'hFFFE, 1'b1);  // 7 / -2
      9:       return make_cmd(OP_DIV, 16'hFFF9, 16'hFFFE, 1'b1);
      10:      return make_cmd(OP_DIV, 16'h8000, 16'hFFFF, 1'b1);  // Wraps to 0x8000
      11:      return make_cmd(OP_DIV, 16'h8000, 16'h0003, 1'b1);
      12:      return make_cmd(OP_DIV, 16'h8000, 16'hFFFF, 1'b0);
      13:      return make_cmd(OP_DIV, 16'h1234, 16'h0000, 1'b0);
      14:      return make_cmd(OP_DIV, 16'h8000, 16'h0000, 1'b1);
      default: return make_cmd(OP_SUB, 16'h8000, 16'h7FFF, 1'b0);
    endcase
  endfunction

  function automatic alu_cmd_t random_cmd();
    alu_cmd_t c;
    int       r;
    c.a         = data_t'($random(seed));
    c.b         = data_t'($random(seed));
    r           = $random(seed);
    c.b         = c.b >> (r & 15);        // Short divisors give long quotients
    c.op        = alu_op_e'((r >> 4) & 3);
    c.is_signed = r[8];
    if (c.op == OP_DIV && ((r >> 9) & 7) == 0) c.b = '0;
    return c;
  endfunction

  // Wrap-around ADD/SUB/MUL and DIV truncating toward zero
  function automatic alu_res_t golden_result(alu_cmd_t c);
    alu_res_t res;
    int       sa;
    int       sb;
    int       q;
    res.data  = '0;
    res.error = 1'b0;
    case (c.op)
      OP_ADD: res.data = c.a + c.b;
      OP_SUB: res.data = c.a - c.b;
      OP_MUL: res.data = c.a * c.b;         // Low W bits only
      default: begin
        if (c.b == '0) begin
          res.error = 1'b1;
        end else if (c.is_signed) begin
          sa = $signed(c.a);
          sb = $signed(c.b);
          q  = (sa < 0 ? -sa : sa) / (sb < 0 ? -sb : sb);
          if ((sa < 0) != (sb < 0)) q = -q;
          res.data = data_t'(q);
        end else begin
          res.data = c.a / c.b;
        end
      end
    endcase
    return res;
  endfunction

  function automatic int latency_of(alu_cmd_t c);
    case (c.op)
      OP_ADD, OP_SUB: return 2;
      OP_MUL:         return W + 2;
      default:        return (c.b == '0) ? 1 : (c.is_signed ? W + 5 : W + 3);
    endcase
  endfunction

  // Back-pressure with about one cycle in four stalled
  initial begin : ready_gen
    i_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      i_ready = ($random(seed) & 3) != 0;
    end
  end

  // Output side sampled at the falling edge where everything is settled
  always @(negedge clk) begin
    if (rst_n && o_valid && !valid_seen) begin
      valid_seen = 1'b1;
      if (cmd_q.size() == 0) begin
        other_errs++;
        $display("Result appeared at %0t with no command in flight", $time);
      end else begin
        exp_lat = latency_of(cmd_q[0]);
        assert (cyc - accept_edge == exp_lat) else begin
          lat_errs++;
          $display("ERR %0t: latency %0d, expected %0d (op %0d a=%h b=%h)", $time,
                   cyc - accept_edge, exp_lat, cmd_q[0].op, cmd_q[0].a, cmd_q[0].b);
        end
      end
    end
    if (rst_n && o_valid && i_ready && cmd_q.size() != 0) begin
      exp_res = golden_result(cmd_q[0]);
      assert (o_res === exp_res) else begin
        value_errs++;
        $display("ERR %0t: op %0d s=%b a=%h b=%h gave %h err %b, expected %h err %b",
                 $time, cmd_q[0].op, cmd_q[0].is_signed, cmd_q[0].a, cmd_q[0].b,
                 o_res.data, o_res.error, exp_res.data, exp_res.error);
      end
      void'(cmd_q.pop_front());
      valid_seen = 1'b0;
      n_checked++;
    end
  end

  initial begin : watchdog
    #(NUM_CMDS * MAX_LAT * PERIOD);
    $display("Run timed out with %0d of %0d results checked", n_checked, NUM_CMDS);
    $display("Test FAILED");
    $finish;
  end

  initial begin : stimulus
    alu_cmd_t cmd;
    int       gap;
    rst_n   = 1'b0;
    i_valid = 1'b0;
    i_cmd   = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    for (int n = 0; n < NUM_CMDS; n++) begin
      cmd = (n < NUM_DIR) ? directed_cmd(n) : random_cmd();
      gap = (($random(seed) & 7) == 0);    // Occasional idle cycle before a command
      @(posedge clk);
      #1;
      if (gap != 0) begin
        i_valid = 1'b0;
        @(posedge clk);
        #1;
      end
      i_cmd   = cmd;
      i_valid = 1'b1;                      // Held while o_ready is low
      do begin
        @(negedge clk);
      end while (!o_ready);
      cmd_q.push_back(cmd);                // Taken on the coming edge
      accept_edge = cyc + 1;
    end
    @(posedge clk);
    #1;
    i_valid = 1'b0;
    wait (n_checked == NUM_CMDS);
    repeat (2) @(posedge clk);
    $display("Summary: %0d results checked, %0d value errors, %0d latency errors, %0d other",
             n_checked, value_errs, lat_errs, other_errs);
    if (value_errs + lat_errs + other_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+.
alu_pkg.sv
alu_decode.sv
alu_control.sv
alu_execute.sv
alu_result.sv
alu.sv
alu_props.sv
alu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ALU testbench with Verilator, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f tb.f --top-module alu_tb -Mdir obj_dir -o alu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/alu_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^Test OK$'; then
  exit 0
fi
exit 1
